// File: logic/dbuf_settings.svh
`ifndef DBUF_SETTINGS_SVH
`define DBUF_SETTINGS_SVH

// ##########################################################################
// DDR side
// ##########################################################################

`define DDR_W           32              // one data beat from either channel.
`define DDR_ADDR_W      16
`define BURST_W         4

// ##########################################################################
// Buffer side
// ##########################################################################

`define BUF_ADDR_W      8
`define PE_NUM          8               // one write enable per PE.

`define INS_W           32
`define JOB_FIFO_DEPTH  4

`endif

// File: logic/dbuf_pkg.sv
`default_nettype none

`include "dbuf_settings.svh"

package dbuf_pkg;

    typedef enum logic [1:0] {
        ADDR = 2'd0,
        LOAD = 2'd1
    } op_t;

    typedef struct packed {
        op_t                    op;
        logic                   chan;           // zero selects ddr1.
        logic [`BURST_W-1:0]    burst;
        logic [4:0]             burst_num;
        logic [11:0]            st_addr;
        logic [7:0]             step;
    } addr_ins_t;

    typedef struct packed {
        op_t                    op;
        logic [`PE_NUM-1:0]     pe_mask;
        logic [`BUF_ADDR_W-1:0] base_addr;
        logic [7:0]             beat_num;
        logic [5:0]             reserved;
    } buf_ins_t;

    // Both views keep op in the top two bits.
    typedef union packed {
        addr_ins_t  addr_ins;
        buf_ins_t   buf_ins;
    } ins_t;

    typedef struct packed {
        logic [`DDR_ADDR_W-1:0] st_addr;
        logic [`BURST_W-1:0]    burst;
        logic [7:0]             step;
        logic [4:0]             burst_num;
    } addr_job_t;

    typedef struct packed {
        logic [`PE_NUM-1:0]     pe_mask;
        logic [`BUF_ADDR_W-1:0] base_addr;
        logic [7:0]             beat_num;
    } buf_job_t;

    typedef struct packed {
        logic [`DDR_ADDR_W-1:0] addr;
        logic [`BURST_W-1:0]    size;
    } ddr_req_t;

    typedef struct packed {
        logic [`DDR_W-1:0]      hi;             // beat from ddr2.
        logic [`DDR_W-1:0]      lo;             // beat from ddr1.
    } dbuf_entry_t;

    typedef struct packed {
        logic [`BUF_ADDR_W-1:0] addr;
        dbuf_entry_t            data;
        logic [`PE_NUM-1:0]     en;
    } dbuf_wr_t;

endpackage

`default_nettype wire

// File: logic/ins_decoder.sv
`default_nettype none

`include "dbuf_settings.svh"

module ins_decoder (
    input  wire logic               clk,
    input  wire logic               rst_n,

    input  wire logic               ins_valid,
    input  wire dbuf_pkg::ins_t     ins,
    output logic                    ins_ready,

    output dbuf_pkg::addr_job_t     ddr1_job,
    output logic                    ddr1_start,
    input  wire logic               ddr1_busy,

    output dbuf_pkg::addr_job_t     ddr2_job,
    output logic                    ddr2_start,
    input  wire logic               ddr2_busy,

    output dbuf_pkg::buf_job_t      job,
    output logic                    push,
    input  wire logic               full
);

    logic                   accept;
    logic                   addr_accept;
    logic                   ddr1_hold;
    logic                   ddr2_hold;
    dbuf_pkg::addr_job_t    addr_job;

    // ##########################################################################
    // Handshake
    // ##########################################################################

    assign ddr1_hold = ddr1_busy | ddr1_start;     // a start in flight counts as busy.
    assign ddr2_hold = ddr2_busy | ddr2_start;

    always_comb begin
        case (ins.addr_ins.op)
            dbuf_pkg::ADDR: ins_ready = ins.addr_ins.chan ? !ddr2_hold : !ddr1_hold;
            dbuf_pkg::LOAD: ins_ready = !full;
            default:        ins_ready = 1'b1;   // undefined ops are dropped.
        endcase
    end

    assign accept      = ins_valid & ins_ready;
    assign addr_accept = accept && (ins.addr_ins.op == dbuf_pkg::ADDR);

    // ##########################################################################
    // Address instructions
    // ##########################################################################

    always_comb begin
        addr_job.st_addr   = {{(`DDR_ADDR_W - $bits(ins.addr_ins.st_addr)){1'b0}},
                              ins.addr_ins.st_addr};
        addr_job.burst     = ins.addr_ins.burst;
        addr_job.step      = ins.addr_ins.step;
        addr_job.burst_num = ins.addr_ins.burst_num;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ddr1_start <= 1'b0;
            ddr2_start <= 1'b0;
        end else begin
            ddr1_start <= addr_accept && !ins.addr_ins.chan;
            ddr2_start <= addr_accept && ins.addr_ins.chan;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_accept && !ins.addr_ins.chan) begin
            ddr1_job <= addr_job;
        end
        if (addr_accept && ins.addr_ins.chan) begin
            ddr2_job <= addr_job;
        end
    end

    // Load jobs go straight into the queue so that full is never stale.
    assign push = accept && (ins.buf_ins.op == dbuf_pkg::LOAD);
    assign job  = '{pe_mask:   ins.buf_ins.pe_mask,
                    base_addr: ins.buf_ins.base_addr,
                    beat_num:  ins.buf_ins.beat_num};

endmodule

`default_nettype wire

// File: logic/ddr_addr_gen.sv
`default_nettype none

`include "dbuf_settings.svh"

module ddr_addr_gen (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire logic                   start,
    input  wire dbuf_pkg::addr_job_t    job,
    output logic                        busy,

    output dbuf_pkg::ddr_req_t          req,
    output logic                        req_valid,
    input  wire logic                   req_ready
);

    logic [4:0]                 remain;
    logic [`DDR_ADDR_W-1:0]     step;
    logic                       fire;
    logic                       last;

    assign fire = req_valid & req_ready;
    assign last = (remain == 5'd1);

    // The run lasts exactly as long as requests are offered.
    assign busy = req_valid;

    // ##########################################################################
    // Run control
    // ##########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            remain    <= '0;
        end else if (start) begin
            req_valid <= (job.burst_num != '0);     // an empty run issues nothing.
            remain    <= job.burst_num;
        end else if (fire) begin
            remain <= remain - 5'd1;
            if (last) begin
                req_valid <= 1'b0;
            end
        end
    end

    // ##########################################################################
    // Request payload
    // ##########################################################################

    always_ff @(posedge clk) begin
        if (start) begin
            req.addr <= job.st_addr;
            req.size <= job.burst;
            step     <= {{(`DDR_ADDR_W - $bits(job.step)){1'b0}}, job.step};
        end else if (fire) begin
            req.addr <= req.addr + step;    // wraps at the top of the DDR space.
        end
    end

endmodule

`default_nettype wire

// File: logic/job_fifo.sv
`default_nettype none

`include "dbuf_settings.svh"

module job_fifo #(
    parameter int DEPTH = `JOB_FIFO_DEPTH
) (
    input  wire logic               clk,
    input  wire logic               rst_n,

    input  wire logic               push,
    input  wire dbuf_pkg::buf_job_t din,
    output logic                    full,

    input  wire logic               pop,
    output dbuf_pkg::buf_job_t      dout,
    output logic                    empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dbuf_pkg::buf_job_t     mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   do_push;
    logic                   do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & !full;
    assign do_pop  = pop & !empty;
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

`default_nettype wire

// File: logic/dbuf_writer.sv
`default_nettype none

`include "dbuf_settings.svh"

module dbuf_writer (
    input  wire logic               clk,
    input  wire logic               rst_n,

    input  wire dbuf_pkg::buf_job_t job,
    input  wire logic               empty,
    output logic                    pop,

    input  wire logic [`DDR_W-1:0]  ddr1_data,
    input  wire logic               ddr1_valid,
    output logic                    ddr1_ready,

    input  wire logic [`DDR_W-1:0]  ddr2_data,
    input  wire logic               ddr2_valid,
    output logic                    ddr2_ready,

    output dbuf_pkg::dbuf_wr_t      dbuf_wr
);

    logic                       active;
    dbuf_pkg::buf_job_t         cur;
    logic [7:0]                 pair_cnt;
    logic                       pair_done;
    logic [1:0]                 hold_full;          // index 0 is ddr1, index 1 is ddr2.
    logic [1:0][`DDR_W-1:0]     hold_data;
    logic [1:0]                 beat_valid;
    logic [1:0]                 beat_ready;
    logic [1:0][`DDR_W-1:0]     beat_data;

    assign beat_valid = {ddr2_valid, ddr1_valid};
    assign beat_data  = {ddr2_data, ddr1_data};
    assign beat_ready = {2{active}} & ~hold_full;
    assign ddr1_ready = beat_ready[0];
    assign ddr2_ready = beat_ready[1];

    assign pair_done = &hold_full;
    assign pop       = !active && !empty;

    // ##########################################################################
    // Job and pair control
    // ##########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            pair_cnt  <= '0;
            hold_full <= '0;
        end else if (pop) begin
            active   <= (job.beat_num != '0);
            pair_cnt <= '0;
        end else if (pair_done) begin
            hold_full <= '0;                // the pair leaves in this cycle.
            pair_cnt  <= pair_cnt + 8'd1;
            if (pair_cnt == cur.beat_num - 8'd1) begin
                active <= 1'b0;
            end
        end else begin
            // Either channel may run one beat ahead of the other.
            hold_full <= hold_full | (beat_valid & beat_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= job;
        end
        for (int i = 0; i < 2; i++) begin
            if (beat_valid[i] && beat_ready[i]) begin
                hold_data[i] <= beat_data[i];
            end
        end
    end

    // ##########################################################################
    // Buffer write
    // ##########################################################################

    always_comb begin
        dbuf_wr.addr    = cur.base_addr + pair_cnt;
        dbuf_wr.data.hi = hold_data[1];
        dbuf_wr.data.lo = hold_data[0];
        dbuf_wr.en      = pair_done ? cur.pe_mask : '0;
    end

endmodule

`default_nettype wire

// File: logic/dbuf_loader_top.sv
`default_nettype none

`include "dbuf_settings.svh"

module dbuf_loader_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire logic                   ins_valid,
    input  wire dbuf_pkg::ins_t         ins,
    output logic                        ins_ready,

    output dbuf_pkg::ddr_req_t          ddr1_req,
    output logic                        ddr1_req_valid,
    input  wire logic                   ddr1_req_ready,

    output dbuf_pkg::ddr_req_t          ddr2_req,
    output logic                        ddr2_req_valid,
    input  wire logic                   ddr2_req_ready,

    input  wire logic [`DDR_W-1:0]      ddr1_data,
    input  wire logic                   ddr1_valid,
    output logic                        ddr1_ready,

    input  wire logic [`DDR_W-1:0]      ddr2_data,
    input  wire logic                   ddr2_valid,
    output logic                        ddr2_ready,

    output dbuf_pkg::dbuf_wr_t          dbuf_wr
);

    dbuf_pkg::addr_job_t    ddr1_job;
    dbuf_pkg::addr_job_t    ddr2_job;
    logic                   ddr1_start;
    logic                   ddr2_start;
    logic                   ddr1_busy;
    logic                   ddr2_busy;

    dbuf_pkg::buf_job_t     push_job;
    dbuf_pkg::buf_job_t     pop_job;
    logic                   push;
    logic                   pop;
    logic                   full;
    logic                   empty;

    ins_decoder ins_decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ins_valid  (ins_valid),
        .ins        (ins),
        .ins_ready  (ins_ready),
        .ddr1_job   (ddr1_job),
        .ddr1_start (ddr1_start),
        .ddr1_busy  (ddr1_busy),
        .ddr2_job   (ddr2_job),
        .ddr2_start (ddr2_start),
        .ddr2_busy  (ddr2_busy),
        .job        (push_job),
        .push       (push),
        .full       (full)
    );

    ddr_addr_gen ddr1_gen_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (ddr1_start),
        .job        (ddr1_job),
        .busy       (ddr1_busy),
        .req        (ddr1_req),
        .req_valid  (ddr1_req_valid),
        .req_ready  (ddr1_req_ready)
    );

    ddr_addr_gen ddr2_gen_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (ddr2_start),
        .job        (ddr2_job),
        .busy       (ddr2_busy),
        .req        (ddr2_req),
        .req_valid  (ddr2_req_valid),
        .req_ready  (ddr2_req_ready)
    );

    job_fifo job_fifo_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .din        (push_job),
        .full       (full),
        .pop        (pop),
        .dout       (pop_job),
        .empty      (empty)
    );

    dbuf_writer dbuf_writer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .job        (pop_job),
        .empty      (empty),
        .pop        (pop),
        .ddr1_data  (ddr1_data),
        .ddr1_valid (ddr1_valid),
        .ddr1_ready (ddr1_ready),
        .ddr2_data  (ddr2_data),
        .ddr2_valid (ddr2_valid),
        .ddr2_ready (ddr2_ready),
        .dbuf_wr    (dbuf_wr)
    );

endmodule

`default_nettype wire

// File: bench/dbuf_loader_tb.sv
`default_nettype none

`include "dbuf_settings.svh"

module dbuf_loader_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LIMIT = 300;

    logic                   clk;
    logic                   rst_n;
    logic                   ins_valid;
    dbuf_pkg::ins_t         ins;
    logic                   ins_ready;
    dbuf_pkg::ddr_req_t     ddr1_req;
    dbuf_pkg::ddr_req_t     ddr2_req;
    logic                   ddr1_req_valid;
    logic                   ddr2_req_valid;
    logic                   ddr1_req_ready;
    logic                   ddr2_req_ready;
    logic [`DDR_W-1:0]      ddr1_data;
    logic [`DDR_W-1:0]      ddr2_data;
    logic                   ddr1_valid;
    logic                   ddr2_valid;
    logic                   ddr1_ready;
    logic                   ddr2_ready;
    dbuf_pkg::dbuf_wr_t     dbuf_wr;

    integer                 seed = 70;
    logic [1:0]             gap_bits;               // a set bit delays the next beat of its channel.
    int                     errors;
    int                     beats_sent [2];
    int                     writes_seen;
    int                     next_beat;
    logic                   both_reqs_seen;
    logic                   req_wait [2];
    dbuf_pkg::ddr_req_t     req_held [2];
    dbuf_pkg::ddr_req_t     req1_q [$];
    dbuf_pkg::ddr_req_t     req2_q [$];
    dbuf_pkg::dbuf_wr_t     wr_q [$];

    dbuf_loader_top dbuf_loader_top_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        #1;
        ddr1_req_ready = ($random(seed) & 3) != 0;
        ddr2_req_ready = ($random(seed) & 3) != 0;
        gap_bits       = 2'($random(seed));
    end

    // ##########################################################################
    // Compare and report
    // ##########################################################################

    task automatic check_req(input dbuf_pkg::ddr_req_t got, input dbuf_pkg::ddr_req_t exp,
                             input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s addr %h size %h, expected addr %h size %h",
                     $time, what, got.addr, got.size, exp.addr, exp.size);
        end
    endtask

    task automatic check_wr(input dbuf_pkg::dbuf_wr_t got, input dbuf_pkg::dbuf_wr_t exp,
                            input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s addr %h data %h en %h, expected addr %h data %h en %h",
                     $time, what, got.addr, got.data, got.en, exp.addr, exp.data, exp.en);
        end
    endtask

    task automatic count_check(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("Fail %0t: wrong number of %s, saw %0d, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task automatic end_run();
        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Gave up waiting for %s at %0t", what, $time);
        end_run();
    endtask

    // ##########################################################################
    // Monitors
    // ##########################################################################

    task automatic watch_req(input int c, input logic v, input logic r,
                             input dbuf_pkg::ddr_req_t q);
        if (v) begin
            if (req_wait[c]) begin
                check_req(q, req_held[c], "stalled request changed");
            end
            if (r) begin
                if (c == 0) req1_q.push_back(q);
                else req2_q.push_back(q);
                req_wait[c] = 1'b0;
            end else begin
                req_wait[c] = 1'b1;
                req_held[c] = q;
            end
        end else if (req_wait[c]) begin
            errors++;
            $display("Request valid on ddr%0d dropped before ready at %0t", c + 1, $time);
            req_wait[c] = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            watch_req(0, ddr1_req_valid, ddr1_req_ready, ddr1_req);
            watch_req(1, ddr2_req_valid, ddr2_req_ready, ddr2_req);
            if (ddr1_req_valid && ddr2_req_valid) both_reqs_seen = 1'b1;
            if (ddr1_valid && ddr1_ready) beats_sent[0]++;
            if (ddr2_valid && ddr2_ready) beats_sent[1]++;
            if (dbuf_wr.en != '0) begin
                if (beats_sent[0] <= writes_seen || beats_sent[1] <= writes_seen) begin
                    errors++;
                    $display("Buffer write at %0t came before both beats were sent", $time);
                end
                wr_q.push_back(dbuf_wr);
                writes_seen++;
            end
        end
    end

    // ##########################################################################
    // Stimulus helpers
    // ##########################################################################

    function automatic dbuf_pkg::ins_t make_addr(input logic chan, input logic [3:0] burst,
                                                 input logic [4:0] num,
                                                 input logic [11:0] st, input logic [7:0] step);
        dbuf_pkg::ins_t w;
        w.addr_ins.op        = dbuf_pkg::ADDR;
        w.addr_ins.chan      = chan;
        w.addr_ins.burst     = burst;
        w.addr_ins.burst_num = num;
        w.addr_ins.st_addr   = st;
        w.addr_ins.step      = step;
        return w;
    endfunction

    function automatic dbuf_pkg::ins_t make_load(input logic [7:0] mask,
                                                 input logic [7:0] base, input logic [7:0] n);
        dbuf_pkg::ins_t w;
        w.buf_ins.op        = dbuf_pkg::LOAD;
        w.buf_ins.pe_mask   = mask;
        w.buf_ins.base_addr = base;
        w.buf_ins.beat_num  = n;
        w.buf_ins.reserved  = '0;
        return w;
    endfunction

    function automatic logic [31:0] beat_word(input int c, input int k);
        return {(c == 0) ? 16'hA1A1 : 16'hB2B2, 16'(k)};
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_ins(input dbuf_pkg::ins_t w);
        int t;
        ins       = w;
        ins_valid = 1'b1;
        t = 0;
        @(negedge clk);
        while (!ins_ready) begin
            t++;
            if (t > LIMIT) report_timeout("ins_ready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        ins_valid = 1'b0;
    endtask

    task automatic send_beat(input int c, input logic [31:0] data);
        int t;
        t = 0;
        @(negedge clk);
        while (gap_bits[c]) begin                   // a random gap comes before the beat.
            t++;
            if (t > LIMIT) report_timeout("a gap to end");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        if (c == 0) {ddr1_valid, ddr1_data} = {1'b1, data};
        else {ddr2_valid, ddr2_data} = {1'b1, data};
        t = 0;
        @(negedge clk);
        while (!((c == 0) ? ddr1_ready : ddr2_ready)) begin
            t++;
            if (t > LIMIT) report_timeout("a data ready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        if (c == 0) ddr1_valid = 1'b0;
        else ddr2_valid = 1'b0;
    endtask

    task automatic drive_stream(input int c, input int n, input int k0);
        for (int j = 0; j < n; j++) send_beat(c, beat_word(c, k0 + j));
    endtask

    task automatic wait_reqs(input int n1, input int n2);
        int t;
        t = 0;
        while (req1_q.size() < n1 || req2_q.size() < n2) begin
            t++;
            if (t > LIMIT) report_timeout("DDR requests");
            @(negedge clk);
        end
    endtask

    task automatic wait_writes(input int n);
        int t;
        t = 0;
        while (wr_q.size() < n) begin
            t++;
            if (t > LIMIT) report_timeout("buffer writes");
            @(negedge clk);
        end
    endtask

    task automatic compare_run(input int c, input int first, input logic [11:0] st,
                               input logic [7:0] step, input logic [3:0] burst, input int n);
        dbuf_pkg::ddr_req_t exp;
        for (int i = 0; i < n; i++) begin
            exp.addr = st + i * step;               // the sum wraps in the 16-bit DDR space.
            exp.size = burst;
            if (c == 0 && first + i < req1_q.size()) check_req(req1_q[first + i], exp, "ddr1");
            if (c == 1 && first + i < req2_q.size()) check_req(req2_q[first + i], exp, "ddr2");
        end
    endtask

    task automatic compare_writes(input int first, input logic [7:0] base,
                                  input logic [7:0] mask, input int n, input int k0);
        dbuf_pkg::dbuf_wr_t exp;
        for (int k = 0; k < n; k++) begin
            exp.addr    = base + k;
            exp.data.lo = beat_word(0, k0 + k);
            exp.data.hi = beat_word(1, k0 + k);
            exp.en      = mask;
            if (first + k < wr_q.size()) check_wr(wr_q[first + k], exp, "buffer write");
        end
    endtask

    // ##########################################################################
    // Directed tests
    // ##########################################################################

    task automatic reset_test();
        for (int op = 0; op < 4; op++) begin
            ins.addr_ins.op = dbuf_pkg::op_t'(op);
            @(negedge clk);
            if (ddr1_req_valid || ddr2_req_valid || dbuf_wr.en != '0 || ddr1_ready
                || ddr2_ready || !ins_ready) begin
                errors++;
                $display("Outputs after reset are not idle for op %0d at %0t", op, $time);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic addr_single_test();
        req1_q.delete();
        send_ins(make_addr(1'b0, 4'h8, 5'd5, 12'hF40, 8'h30));
        wait_reqs(5, 0);
        idle(8);
        count_check("ddr1 requests", req1_q.size(), 5);
        compare_run(0, 0, 12'hF40, 8'h30, 4'h8, 5);
    endtask

    task automatic dual_addr_test();
        int t;
        req1_q.delete();
        req2_q.delete();
        both_reqs_seen = 1'b0;
        send_ins(make_addr(1'b0, 4'h4, 5'd6, 12'h100, 8'h40));
        send_ins(make_addr(1'b1, 4'hC, 5'd4, 12'hABC, 8'hFF));
        ins       = make_addr(1'b0, 4'h2, 5'd3, 12'h7F0, 8'h08);
        ins_valid = 1'b1;
        @(negedge clk);
        if (ins_ready) begin
            errors++;
            $display("Second ddr1 address instruction was not held off at %0t", $time);
        end
        t = 0;
        while (!ins_ready) begin
            t++;
            if (t > LIMIT) report_timeout("the ddr1 run to end");
            @(negedge clk);
        end
        count_check("ddr1 requests before the next run", req1_q.size(), 6);
        @(posedge clk);
        #1;
        ins_valid = 1'b0;
        wait_reqs(9, 4);
        idle(8);
        if (!both_reqs_seen) begin
            errors++;
            $display("The ddr1 and ddr2 runs never overlapped at %0t", $time);
        end
        count_check("ddr1 requests", req1_q.size(), 9);
        count_check("ddr2 requests", req2_q.size(), 4);
        compare_run(0, 0, 12'h100, 8'h40, 4'h4, 6);
        compare_run(1, 0, 12'hABC, 8'hFF, 4'hC, 4);
        compare_run(0, 6, 12'h7F0, 8'h08, 4'h2, 3);
    endtask

    task automatic load_run(input logic [7:0] mask, input logic [7:0] base, input int n);
        int k0;
        k0 = next_beat;
        next_beat += n;
        wr_q.delete();
        send_ins(make_load(mask, base, 8'(n)));
        fork
            drive_stream(0, n, k0);
            drive_stream(1, n, k0);
        join
        wait_writes(n);
        idle(4);
        count_check("buffer writes", wr_q.size(), n);
        compare_writes(0, base, mask, n, k0);
    endtask

    task automatic queue_full_test();
        int k0;
        k0 = next_beat;
        next_beat += 12;
        wr_q.delete();
        for (int j = 0; j < 5; j++) send_ins(make_load(8'(1 << j), 8'(8'h10 * j), 8'd2));
        ins       = make_load(8'h80, 8'hFF, 8'd2);  // this sixth job must wait.
        ins_valid = 1'b1;
        repeat (6) begin
            @(negedge clk);
            if (ins_ready) begin
                errors++;
                $display("Sixth load instruction was not held off at %0t", $time);
            end
        end
        @(posedge clk);
        #1;
        fork
            send_ins(make_load(8'h80, 8'hFF, 8'd2));
            drive_stream(0, 12, k0);
            drive_stream(1, 12, k0);
        join
        wait_writes(12);
        idle(4);
        count_check("buffer writes", wr_q.size(), 12);
        for (int j = 0; j < 5; j++) begin
            compare_writes(2 * j, 8'(8'h10 * j), 8'(1 << j), 2, k0 + 2 * j);
        end
        compare_writes(10, 8'hFF, 8'h80, 2, k0 + 10);
    endtask

    task automatic bad_op_test();
        dbuf_pkg::ins_t w;
        req1_q.delete();
        req2_q.delete();
        wr_q.delete();
        w = make_load(8'hFF, 8'h00, 8'd4);
        w.buf_ins.op = dbuf_pkg::op_t'(2'd3);
        send_ins(w);
        idle(10);
        count_check("requests after an undefined op", req1_q.size() + req2_q.size(), 0);
        count_check("writes after an undefined op", wr_q.size(), 0);
        load_run(8'h81, 8'h20, 3);
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        ins_valid      = 1'b0;
        ins            = '0;
        ddr1_req_ready = 1'b0;
        ddr2_req_ready = 1'b0;
        ddr1_data      = '0;
        ddr2_data      = '0;
        ddr1_valid     = 1'b0;
        ddr2_valid     = 1'b0;
        gap_bits       = '0;
        errors         = 0;
        beats_sent     = '{0, 0};
        writes_seen    = 0;
        next_beat      = 0;
        both_reqs_seen = 1'b0;
        req_wait       = '{1'b0, 1'b0};
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_test();
        addr_single_test();
        dual_addr_test();
        load_run(8'h5A, 8'hFD, 6);                  // base near the top checks the wrap.
        queue_full_test();
        bad_op_test();
        idle(4);
        end_run();
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/dbuf_pkg.sv
logic/ins_decoder.sv
logic/ddr_addr_gen.sv
logic/job_fifo.sv
logic/dbuf_writer.sv
logic/dbuf_loader_top.sv
bench/dbuf_loader_tb.sv
